/* verilog/boardcfg_pkg.sv */
package boardcfg_pkg;

	typedef logic [31:0] word_t;	// Host register word
	typedef logic [7:0] led_t;	// Board LED vector

	// Control register layout, LSB first from led_pattern
	typedef struct packed {
		logic [19:0] reserved;
		logic soft_reset;	// Self-clearing, never stored
		logic capture_hold;	// Freezes both ADC channels
		logic [1:0] led_mode;	// 0 pattern, 1 heartbeat, 2 adc0 msbs, 3 off
		led_t led_pattern;
	} ctrl_fields_t;

	// A written word seen either as plain data or as control fields
	typedef union packed {
		word_t raw;
		ctrl_fields_t ctrl;
	} reg_word_u;

	// Word addresses on the host bus
	localparam logic [7:0] ADDR_ID = 8'd0;
	localparam logic [7:0] ADDR_CTRL = 8'd1;
	localparam logic [7:0] ADDR_SCRATCH = 8'd2;
	localparam logic [7:0] ADDR_ADC0_LAST = 8'd3;
	localparam logic [7:0] ADDR_ADC1_LAST = 8'd4;
	localparam logic [7:0] ADDR_ADC0_COUNT = 8'd5;
	localparam logic [7:0] ADDR_ADC1_COUNT = 8'd6;
	localparam logic [7:0] ADDR_STATUS = 8'd7;
	localparam logic [7:0] ADDR_FREQ_BASE = 8'd8;	// One word per measured input

	localparam word_t BOARD_ID = 32'hB0C5_0102;	// Constant board identification
	localparam word_t DEAD_WORD = 32'hDEAD_BEEF;	// Unmapped addresses

	// Pattern, mode and hold are kept; soft_reset and reserved read back 0
	localparam word_t CTRL_WRITABLE_MASK = 32'h0000_07FF;

	localparam int SAMPLE_WIDTH = 16;	// ADC sample width

endpackage

/* verilog/reset_stretch.sv */
module reset_stretch #(
	parameter int SRWIDTH = 4
) (
	input logic hw,
	input logic reset,
	input logic soft_reset_pulse,
	output logic sys_reset
);

	logic [SRWIDTH-1:0] stretch;	// Ones fill in, zeros drain out
	logic any_reset;

	assign any_reset = reset | soft_reset_pulse;	// Either source restarts the hold

	always_ff @(posedge hw) begin
		if (any_reset) begin
			stretch <= '1;	// Load the whole chain
		end else begin
			stretch <= stretch << 1;	// Drain one stage per cycle
		end
	end

	// Last stage is the clean system reset
	assign sys_reset = stretch[SRWIDTH-1];

endmodule

/* verilog/freq_meter_bank.sv */
module freq_meter_bank import boardcfg_pkg::*; #(
	parameter int NCLK = 4,
	parameter int GATE_CYCLES = 512
) (
	input logic hw,
	input logic sys_reset,
	input logic [NCLK-1:0] meas_in,
	output word_t freq_counts [NCLK],
	output logic freq_ready
);

	localparam int GW = (GATE_CYCLES > 1) ? $clog2(GATE_CYCLES) : 1;
	localparam logic [GW-1:0] GATE_LAST = GW'(GATE_CYCLES - 1);

	logic [NCLK-1:0] sync1;	// First synchronizer stage
	logic [NCLK-1:0] sync2;	// Second stage, safe to use
	logic [NCLK-1:0] prev;	// Delayed copy for edge detect
	logic [NCLK-1:0] rise;
	logic [GW-1:0] gate_cnt;	// Shared window timer
	logic gate_end;
	word_t edge_cnt [NCLK];

	// Two-flop synchronizer then rising-edge detect
	always_ff @(posedge hw) begin
		if (sys_reset) begin
			sync1 <= '0;
			sync2 <= '0;
			prev <= '0;
		end else begin
			sync1 <= meas_in;
			sync2 <= sync1;
			prev <= sync2;
		end
	end

	assign rise = sync2 & ~prev;

	// Gate timer restarts when sys_reset drops
	always_ff @(posedge hw) begin
		if (sys_reset) begin
			gate_cnt <= '0;
		end else if (gate_end) begin
			gate_cnt <= '0;
		end else begin
			gate_cnt <= gate_cnt + 1'b1;
		end
	end

	assign gate_end = (gate_cnt == GATE_LAST);	// Last cycle of the window

	// Per-input counters, latched and restarted at the end of each window
	always_ff @(posedge hw) begin
		if (sys_reset) begin
			for (int i = 0; i < NCLK; i++) begin
				edge_cnt[i] <= '0;
				freq_counts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NCLK; i++) begin
				if (gate_end) begin
					freq_counts[i] <= edge_cnt[i];	// Publish this window
					edge_cnt[i] <= word_t'(rise[i]);	// Edge in the boundary cycle goes to next window
				end else if (rise[i] && (edge_cnt[i] != '1)) begin
					edge_cnt[i] <= edge_cnt[i] + 1'b1;	// Saturates at all ones
				end
			end
		end
	end

	// Sticky once the first result is out
	always_ff @(posedge hw) begin
		if (sys_reset) begin
			freq_ready <= 1'b0;
		end else if (gate_end) begin
			freq_ready <= 1'b1;
		end
	end

endmodule

/* verilog/sample_capture.sv */
module sample_capture import boardcfg_pkg::*; (
	input logic hw,
	input logic sys_reset,
	input logic capture_hold,
	input logic [SAMPLE_WIDTH-1:0] adc0_data,
	input logic adc0_valid,
	input logic [SAMPLE_WIDTH-1:0] adc1_data,
	input logic adc1_valid,
	output logic [SAMPLE_WIDTH-1:0] adc0_last,
	output logic [SAMPLE_WIDTH-1:0] adc1_last,
	output word_t adc0_count,
	output word_t adc1_count
);

	logic [SAMPLE_WIDTH-1:0] data_in [2];	// Both channels as one array
	logic [1:0] valid_in;
	logic [SAMPLE_WIDTH-1:0] last_q [2];
	word_t count_q [2];

	assign data_in[0] = adc0_data;
	assign data_in[1] = adc1_data;
	assign valid_in = {adc1_valid, adc0_valid};

	// Same logic for each channel, hold freezes both
	always_ff @(posedge hw) begin
		if (sys_reset) begin
			for (int ch = 0; ch < 2; ch++) begin
				last_q[ch] <= '0;
				count_q[ch] <= '0;
			end
		end else if (!capture_hold) begin
			for (int ch = 0; ch < 2; ch++) begin
				if (valid_in[ch]) begin
					last_q[ch] <= data_in[ch];	// Keep newest sample
					count_q[ch] <= count_q[ch] + 1'b1;	// Wraps
				end
			end
		end
	end

	assign adc0_last = last_q[0];
	assign adc1_last = last_q[1];
	assign adc0_count = count_q[0];
	assign adc1_count = count_q[1];

endmodule

/* verilog/cfg_regs.sv */
module cfg_regs import boardcfg_pkg::*; #(
	parameter int NCLK = 4,
	parameter int HEARTBEAT_SHIFT = 20
) (
	input logic hw,
	input logic reset,
	input logic [7:0] reg_addr,
	input word_t reg_wdata,
	input logic reg_we,
	input logic reg_re,
	output word_t reg_rdata,
	output logic reg_rvalid,
	input word_t freq_counts [NCLK],
	input logic freq_ready,
	input logic [SAMPLE_WIDTH-1:0] adc0_last,
	input logic [SAMPLE_WIDTH-1:0] adc1_last,
	input word_t adc0_count,
	input word_t adc1_count,
	output logic capture_hold,
	output logic soft_reset_pulse,
	output led_t leds
);

	reg_word_u wr_word;	// Incoming write, seen both ways
	reg_word_u ctrl_q;	// Stored control word, masked
	word_t scratch_q;
	word_t rd_mux;
	logic [HEARTBEAT_SHIFT+7:0] hb_cnt;	// Free-running heartbeat

	assign wr_word.raw = reg_wdata;

	// Control and scratch survive soft reset, only the board reset clears them
	always_ff @(posedge hw) begin
		if (reset) begin
			ctrl_q.raw <= '0;
			scratch_q <= '0;
			soft_reset_pulse <= 1'b0;
		end else begin
			soft_reset_pulse <= 1'b0;	// One-cycle pulse by default
			if (reg_we) begin
				if (reg_addr == ADDR_CTRL) begin
					ctrl_q.raw <= wr_word.raw & CTRL_WRITABLE_MASK;
					soft_reset_pulse <= wr_word.ctrl.soft_reset;
				end
				if (reg_addr == ADDR_SCRATCH) begin
					scratch_q <= wr_word.raw;	// Plain word, no decode
				end
			end
		end
	end

	// Read map
	always_comb begin
		case (reg_addr)
			ADDR_ID: rd_mux = BOARD_ID;
			ADDR_CTRL: rd_mux = ctrl_q.raw;
			ADDR_SCRATCH: rd_mux = scratch_q;
			ADDR_ADC0_LAST: rd_mux = word_t'(adc0_last);	// Zero-extended
			ADDR_ADC1_LAST: rd_mux = word_t'(adc1_last);
			ADDR_ADC0_COUNT: rd_mux = adc0_count;
			ADDR_ADC1_COUNT: rd_mux = adc1_count;
			ADDR_STATUS: rd_mux = {30'd0, ctrl_q.ctrl.capture_hold, freq_ready};
			default: begin
				rd_mux = DEAD_WORD;
				for (int i = 0; i < NCLK; i++) begin
					if (reg_addr == 8'(ADDR_FREQ_BASE + i)) begin
						rd_mux = freq_counts[i];	// Frequency window
					end
				end
			end
		endcase
	end

	// Reply one cycle after the read strobe
	always_ff @(posedge hw) begin
		if (reset) begin
			reg_rvalid <= 1'b0;
		end else begin
			reg_rvalid <= reg_re;
		end
	end

	always_ff @(posedge hw) begin
		if (reg_re) begin
			reg_rdata <= rd_mux;	// Latch the addressed word
		end
	end

	always_ff @(posedge hw) begin
		if (reset) begin
			hb_cnt <= '0;
		end else begin
			hb_cnt <= hb_cnt + 1'b1;
		end
	end

	assign capture_hold = ctrl_q.ctrl.capture_hold;

	// LED source select from the stored mode
	always_comb begin
		case (ctrl_q.ctrl.led_mode)
			2'd0: leds = ctrl_q.ctrl.led_pattern;
			2'd1: leds = hb_cnt[HEARTBEAT_SHIFT +: 8];	// Slow blink bits
			2'd2: leds = adc0_last[SAMPLE_WIDTH-1 -: 8];	// ADC0 msbs
			default: leds = '0;	// All off
		endcase
	end

endmodule

/* verilog/boardcfg_top.sv */
module boardcfg_top import boardcfg_pkg::*; #(
	parameter int NCLK = 4,
	parameter int GATE_CYCLES = 512,
	parameter int SRWIDTH = 4,
	parameter int HEARTBEAT_SHIFT = 20
) (
	input logic hw,
	input logic reset,
	input logic [7:0] reg_addr,
	input word_t reg_wdata,
	input logic reg_we,
	input logic reg_re,
	output word_t reg_rdata,
	output logic reg_rvalid,
	input logic [NCLK-1:0] meas_in,
	input logic [SAMPLE_WIDTH-1:0] adc0_data,
	input logic adc0_valid,
	input logic [SAMPLE_WIDTH-1:0] adc1_data,
	input logic adc1_valid,
	output led_t leds
);

	logic sys_reset;	// Stretched board plus soft reset
	logic soft_reset_pulse;
	logic capture_hold;
	logic freq_ready;
	word_t freq_counts [NCLK];
	logic [SAMPLE_WIDTH-1:0] adc0_last;
	logic [SAMPLE_WIDTH-1:0] adc1_last;
	word_t adc0_count;
	word_t adc1_count;

	reset_stretch #(.SRWIDTH(SRWIDTH)) reset_stretch_inst (
		.hw(hw), .reset(reset), .soft_reset_pulse(soft_reset_pulse), .sys_reset(sys_reset)
	);

	freq_meter_bank #(.NCLK(NCLK), .GATE_CYCLES(GATE_CYCLES)) freq_meter_bank_inst (
		.hw(hw), .sys_reset(sys_reset), .meas_in(meas_in),
		.freq_counts(freq_counts), .freq_ready(freq_ready)
	);

	sample_capture sample_capture_inst (
		.hw(hw), .sys_reset(sys_reset), .capture_hold(capture_hold),
		.adc0_data(adc0_data), .adc0_valid(adc0_valid),
		.adc1_data(adc1_data), .adc1_valid(adc1_valid),
		.adc0_last(adc0_last), .adc1_last(adc1_last),
		.adc0_count(adc0_count), .adc1_count(adc1_count)
	);

	// Register bank on the board reset only
	cfg_regs #(.NCLK(NCLK), .HEARTBEAT_SHIFT(HEARTBEAT_SHIFT)) cfg_regs_inst (
		.hw(hw), .reset(reset),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we), .reg_re(reg_re),
		.reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid),
		.freq_counts(freq_counts), .freq_ready(freq_ready),
		.adc0_last(adc0_last), .adc1_last(adc1_last),
		.adc0_count(adc0_count), .adc1_count(adc1_count),
		.capture_hold(capture_hold), .soft_reset_pulse(soft_reset_pulse), .leds(leds)
	);

endmodule

/* bench/boardcfg_props.sv */
module boardcfg_props import boardcfg_pkg::*; (
	input logic hw,
	input logic reset,
	input logic reg_re,
	input logic reg_rvalid,
	input led_t leds,
	input logic sys_reset
);

	// Read reply comes exactly one cycle after the strobe
	rvalid_follows_re: assert property (
		@(posedge hw) !reset |=> (reg_rvalid == $past(reg_re))
	) else $error("reg_rvalid does not follow reg_re by one cycle");

	// Control word cleared, so pattern mode shows zero
	leds_clear_after_reset: assert property (
		@(posedge hw) reset |=> (leds == '0)
	) else $error("leds not zero after reset");

	sys_reset_after_reset: assert property (
		@(posedge hw) reset |=> sys_reset
	) else $error("sys_reset low in the cycle after reset");

endmodule

bind boardcfg_top boardcfg_props boardcfg_props_inst (
	.hw(hw), .reset(reset), .reg_re(reg_re), .reg_rvalid(reg_rvalid),
	.leds(leds), .sys_reset(sys_reset)
);

/* include/boardcfg_tests.svh */
`ifndef BOARDCFG_TESTS_SVH
`define BOARDCFG_TESTS_SVH

	task automatic verify_reset_values();
		int errors_before;
		errors_before = error_count;
		expect_read(ADDR_ID, "id", BOARD_ID);
		expect_read(ADDR_CTRL, "ctrl", '0);
		expect_read(ADDR_STATUS, "status", '0);	// First window not over yet
		expect_read(ADDR_ADC0_LAST, "adc0_last", '0);
		expect_read(ADDR_ADC1_LAST, "adc1_last", '0);
		expect_read(ADDR_ADC0_COUNT, "adc0_count", '0);
		expect_read(ADDR_ADC1_COUNT, "adc1_count", '0);
		for (int i = 0; i < NCLK; i++) begin
			expect_read(8'(ADDR_FREQ_BASE + i), $sformatf("freq%0d", i), '0);
		end
		expect_read(8'hF0, "unmapped", DEAD_WORD);
		check_leds("leds", leds, '0);
		report_test("reset state", errors_before);
	endtask

	task automatic access_registers();
		int errors_before;
		word_t value;
		reg_word_u ctrl_word;
		errors_before = error_count;
		for (int n = 0; n < 4; n++) begin
			value = $random(seed);
			bus_write(ADDR_SCRATCH, value);
			expect_read(ADDR_SCRATCH, "scratch", value);
			ctrl_word.raw = $random(seed);
			ctrl_word.ctrl.soft_reset = 1'b0;	// Keep the datapath state
			bus_write(ADDR_CTRL, ctrl_word.raw);
			expect_read(ADDR_CTRL, "ctrl", ctrl_word.raw & CTRL_WRITABLE_MASK);
		end
		bus_write(ADDR_CTRL, '0);	// Pattern mode, no hold
		report_test("register access", errors_before);
	endtask

	task automatic measure_frequencies();
		int errors_before;
		int polls;
		word_t status;
		word_t count;
		errors_before = error_count;
		meas_run = 1'b1;
		polls = 0;
		status = '0;
		while (!status[0] && polls < GATE_CYCLES) begin
			bus_read(ADDR_STATUS, status);
			polls++;
		end
		if (!status[0]) begin
			error_count++;
			$display("Error at %0t: freq_ready never came up", $time);
		end
		repeat (GATE_CYCLES + 16) @(negedge hw);	// One full window with toggling inputs
		for (int i = 0; i < NCLK; i++) begin
			bus_read(8'(ADDR_FREQ_BASE + i), count);
			check_freq($sformatf("freq%0d", i), count,
				word_t'(GATE_CYCLES / (2 * TOGGLE_PERIOD[i])));
		end
		meas_run = 1'b0;
		report_test("frequency meter", errors_before);
	endtask

	// Random samples with gaps, the model follows only when they are accepted
	task automatic drive_samples(input int cycles, input logic accepted);
		word_t rnd;
		for (int n = 0; n < cycles; n++) begin
			@(negedge hw);
			rnd = $random(seed);
			adc0_data = rnd[15:0];
			adc1_data = rnd[31:16];
			rnd = $random(seed);
			adc0_valid = rnd[0];
			adc1_valid = rnd[1];
			if (accepted && adc0_valid) begin
				model_adc0_last = adc0_data;
				model_adc0_count++;
			end
			if (accepted && adc1_valid) begin
				model_adc1_last = adc1_data;
				model_adc1_count++;
			end
		end
		@(negedge hw);
		adc0_valid = 1'b0;
		adc1_valid = 1'b0;
	endtask

	task automatic capture_samples();
		int errors_before;
		reg_word_u ctrl_word;
		errors_before = error_count;
		drive_samples(40, 1'b1);
		expect_read(ADDR_ADC0_LAST, "adc0_last", word_t'(model_adc0_last));
		expect_read(ADDR_ADC1_LAST, "adc1_last", word_t'(model_adc1_last));
		expect_read(ADDR_ADC0_COUNT, "adc0_count", model_adc0_count);
		expect_read(ADDR_ADC1_COUNT, "adc1_count", model_adc1_count);
		ctrl_word.raw = '0;
		ctrl_word.ctrl.capture_hold = 1'b1;
		bus_write(ADDR_CTRL, ctrl_word.raw);
		expect_read(ADDR_STATUS, "status", 32'h3);	// Hold plus ready
		drive_samples(20, 1'b0);
		expect_read(ADDR_ADC0_LAST, "adc0_last", word_t'(model_adc0_last));
		expect_read(ADDR_ADC1_LAST, "adc1_last", word_t'(model_adc1_last));
		expect_read(ADDR_ADC0_COUNT, "adc0_count", model_adc0_count);
		expect_read(ADDR_ADC1_COUNT, "adc1_count", model_adc1_count);
		bus_write(ADDR_CTRL, '0);
		report_test("sample capture", errors_before);
	endtask

	task automatic cycle_led_modes();
		int errors_before;
		reg_word_u ctrl_word;
		errors_before = error_count;
		ctrl_word.raw = '0;
		ctrl_word.ctrl.led_pattern = 8'($random(seed));
		bus_write(ADDR_CTRL, ctrl_word.raw);
		check_leds("leds", leds, ctrl_word.ctrl.led_pattern);
		ctrl_word.ctrl.led_mode = 2'd2;	// ADC0 msbs
		bus_write(ADDR_CTRL, ctrl_word.raw);
		check_leds("leds", leds, model_adc0_last[SAMPLE_WIDTH-1 -: 8]);
		ctrl_word.ctrl.led_mode = 2'd3;
		bus_write(ADDR_CTRL, ctrl_word.raw);
		check_leds("leds", leds, '0);
		report_test("led modes", errors_before);
	endtask

	task automatic apply_soft_reset();
		int errors_before;
		word_t scratch;
		reg_word_u ctrl_word;
		errors_before = error_count;
		scratch = $random(seed);
		bus_write(ADDR_SCRATCH, scratch);
		ctrl_word.raw = '0;
		ctrl_word.ctrl.led_pattern = 8'h5A;
		ctrl_word.ctrl.soft_reset = 1'b1;
		bus_write(ADDR_CTRL, ctrl_word.raw);
		repeat (SRWIDTH + 4) @(negedge hw);
		expect_read(ADDR_ADC0_COUNT, "adc0_count", '0);
		expect_read(ADDR_ADC1_COUNT, "adc1_count", '0);
		expect_read(ADDR_STATUS, "status", '0);
		for (int i = 0; i < NCLK; i++) begin
			expect_read(8'(ADDR_FREQ_BASE + i), $sformatf("freq%0d", i), '0);
		end
		expect_read(ADDR_SCRATCH, "scratch", scratch);
		ctrl_word.ctrl.soft_reset = 1'b0;	// Never stored
		expect_read(ADDR_CTRL, "ctrl", ctrl_word.raw);
		report_test("soft reset", errors_before);
	endtask

`endif

/* bench/boardcfg_tb.sv */
module boardcfg_tb import boardcfg_pkg::*; ();

	localparam int NCLK = 4;
	localparam int GATE_CYCLES = 512;
	localparam int SRWIDTH = 4;
	localparam int HEARTBEAT_SHIFT = 20;
	localparam int TIMEOUT_CYCLES = 8 * GATE_CYCLES + 2000;	// Frequency test needs about two windows
	localparam int TOGGLE_PERIOD [NCLK] = '{2, 3, 5, 8};	// Half periods of the measured inputs

	logic hw = 1'b0;
	logic reset;
	logic [7:0] reg_addr;
	word_t reg_wdata;
	logic reg_we;
	logic reg_re;
	word_t reg_rdata;
	logic reg_rvalid;
	logic [NCLK-1:0] meas_in = '0;
	logic [SAMPLE_WIDTH-1:0] adc0_data;
	logic adc0_valid;
	logic [SAMPLE_WIDTH-1:0] adc1_data;
	logic adc1_valid;
	led_t leds;

	integer seed;
	int error_count;
	int check_count;
	int test_count;
	int cycle_count;
	logic meas_run;	// Starts the toggle generator
	int toggle_cnt [NCLK];
	logic [SAMPLE_WIDTH-1:0] model_adc0_last;	// Reference model of the capture block
	logic [SAMPLE_WIDTH-1:0] model_adc1_last;
	word_t model_adc0_count;
	word_t model_adc1_count;

	boardcfg_top #(
		.NCLK(NCLK), .GATE_CYCLES(GATE_CYCLES), .SRWIDTH(SRWIDTH), .HEARTBEAT_SHIFT(HEARTBEAT_SHIFT)
	) boardcfg_top_inst (
		.hw(hw), .reset(reset),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we), .reg_re(reg_re),
		.reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid), .meas_in(meas_in),
		.adc0_data(adc0_data), .adc0_valid(adc0_valid),
		.adc1_data(adc1_data), .adc1_valid(adc1_valid), .leds(leds)
	);

	initial begin
		forever #2 hw = ~hw;
	end

	always @(posedge hw) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("** FAIL **");
			$finish;
		end
	end

	// Each input flips after its own number of cycles
	always @(negedge hw) begin
		if (meas_run) begin
			for (int i = 0; i < NCLK; i++) begin
				if (toggle_cnt[i] == TOGGLE_PERIOD[i] - 1) begin
					meas_in[i] <= ~meas_in[i];
					toggle_cnt[i] <= 0;
				end else begin
					toggle_cnt[i] <= toggle_cnt[i] + 1;
				end
			end
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_leds(input string name, input led_t got, input led_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Measured rate allows one count of slack
	task automatic check_freq(input string name, input word_t got, input word_t exp);
		check_count++;
		if ((got > exp + 1) || (got + 1 < exp)) begin
			error_count++;
			$display("MISMATCH at %0t: %s got %0d expected %0d +/- 1", $time, name, got, exp);
		end
	endtask

	task automatic bus_write(input logic [7:0] addr, input word_t data);
		@(negedge hw);
		reg_addr = addr;
		reg_wdata = data;
		reg_we = 1'b1;
		@(negedge hw);
		reg_we = 1'b0;	// Write has landed by now
	endtask

	task automatic bus_read(input logic [7:0] addr, output word_t data);
		int waited;
		@(negedge hw);
		reg_addr = addr;
		reg_re = 1'b1;
		@(negedge hw);
		reg_re = 1'b0;
		waited = 0;
		while (!reg_rvalid && waited < 4) begin
			@(negedge hw);
			waited++;
		end
		if (!reg_rvalid) begin
			error_count++;
			$display("Error at %0t: read of address %0d got no reply", $time, addr);
		end
		data = reg_rdata;
	endtask

	task automatic expect_read(input logic [7:0] addr, input string name, input word_t exp);
		word_t got;
		bus_read(addr, got);
		check_word(name, got, exp);
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

`include "boardcfg_tests.svh"

	initial begin
		seed = 32'h2666;
		reset = 1'b1;
		reg_addr = '0;
		reg_wdata = '0;
		reg_we = 1'b0;
		reg_re = 1'b0;
		adc0_data = '0;
		adc0_valid = 1'b0;
		adc1_data = '0;
		adc1_valid = 1'b0;
		meas_run = 1'b0;
		model_adc0_last = '0;
		model_adc1_last = '0;
		model_adc0_count = '0;
		model_adc1_count = '0;
		repeat (16) @(negedge hw);
		reset = 1'b0;
		verify_reset_values();
		access_registers();
		measure_frequencies();
		capture_samples();
		cycle_led_modes();
		apply_soft_reset();
		$display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+include
verilog/boardcfg_pkg.sv
verilog/reset_stretch.sv
verilog/freq_meter_bank.sv
verilog/sample_capture.sv
verilog/cfg_regs.sv
verilog/boardcfg_top.sv
bench/boardcfg_props.sv
bench/boardcfg_tb.sv

/* run_sim.sh */
#!/bin/bash
# Compile and run the boardcfg testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module boardcfg_tb \
	-Mdir obj_dir -o boardcfg_sim > build.log 2>&1 \
	&& ./obj_dir/boardcfg_sim > sim.log 2>&1 \
	|| echo "** FAIL **" >> sim.log

cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "Simulation failed, see build.log and sim.log"; exit 1; }
echo "Simulation passed"
exit 0
